//--- decode_stage_config.svh
`ifndef DECODE_STAGE_CONFIG_SVH
`define DECODE_STAGE_CONFIG_SVH

`define DATA_W 32
`define INST_W 64
`define REG_AW 5
`define REG_N 32

// instruction word layout
`define MEMK_HI 63
`define MEMK_LO 60
`define OP_HI 59
`define OP_LO 52
`define RD_HI 51
`define RD_LO 47
`define RS1_HI 46
`define RS1_LO 42
`define RS2_HI 41
`define RS2_LO 37
`define IMM_HI 41
`define IMM_LO 10
`define JTGT_HI 51 // overlaps rd/rs fields, jumps only
`define JTGT_LO 20

`endif

//--- source/decode_pkg.sv
`include "decode_stage_config.svh"

package decode_pkg;

	typedef enum logic [3:0] {
		MEMK_SREG = 4'h1, // reg-imm form
		MEMK_DREG = 4'h2 // reg-reg form
	} mem_kind_e;

	typedef enum logic [7:0] {
		OP_OR = 8'h01, OP_AND = 8'h02, OP_XOR = 8'h03,
		OP_SHL = 8'h05, OP_SHR = 8'h06, OP_SAR = 8'h07,
		OP_ADD = 8'h10, OP_SUB = 8'h11,
		OP_JMP = 8'h20, OP_JE = 8'h21, OP_JNE = 8'h22, OP_JG = 8'h23,
		OP_JL = 8'h24, OP_JNG = 8'h25, OP_JNL = 8'h26
	} opcode_e;

	// order matters, alu ops first and then jumps
	typedef enum logic [4:0] {
		ALU_NOP = 5'd0, ALU_OR, ALU_AND, ALU_XOR, ALU_SHL, ALU_SHR, ALU_SAR,
		ALU_ADD, ALU_SUB, ALU_JMP, ALU_JE, ALU_JNE, ALU_JG, ALU_JL, ALU_JNG, ALU_JNL
	} aluop_e;

	typedef enum logic [2:0] {
		CND_EQ, CND_NE, CND_GT, CND_LT, CND_LE, CND_GE
	} cond_e;

	typedef struct packed {
		logic [`INST_W-1:0] inst;
		logic [`DATA_W-1:0] pc;
	} fetch_pkt_t;

	typedef struct packed {
		logic we;
		logic [`REG_AW-1:0] addr;
		logic [`DATA_W-1:0] data;
	} fwd_t;

	typedef struct packed {
		aluop_e aluop;
		logic use_a;
		logic use_b;
		logic [`REG_AW-1:0] a_addr;
		logic [`REG_AW-1:0] b_addr;
		logic [`DATA_W-1:0] imm;
		logic [`REG_AW-1:0] rd;
		logic wreg;
		logic is_jump;
		logic is_cond;
		cond_e cond;
		logic illegal;
	} dec_ctrl_t;

	typedef struct packed {
		aluop_e aluop;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`REG_AW-1:0] rd;
		logic wreg;
		logic branch;
		logic [`DATA_W-1:0] target;
		logic illegal;
	} issue_pkt_t;

endpackage

//--- source/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  payload_t in_data_i,
	output logic     out_valid_o,
	input  logic     out_ready_i,
	output payload_t out_data_o
);

	logic     valid_q;
	payload_t data_q;

	// take a new item when empty or when the current one leaves
	assign in_ready_o = !valid_q || out_ready_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (in_ready_o) begin
			valid_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_data_i;
		end
	end

	assign out_valid_o = valid_q;
	assign out_data_o = data_q;

	hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps
`include "decode_stage_config.svh"

module reg_file import decode_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  fwd_t               wr_i,
	input  logic [`REG_AW-1:0] ra_addr_i,
	input  logic [`REG_AW-1:0] rb_addr_i,
	output logic [`DATA_W-1:0] ra_data_o,
	output logic [`DATA_W-1:0] rb_data_o
);

	logic [`DATA_W-1:0] regs [`REG_N];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_i.we) begin
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	// no write-through, a same-cycle write shows up next cycle
	assign ra_data_o = regs[ra_addr_i];
	assign rb_data_o = regs[rb_addr_i];

endmodule

//--- source/operand_bypass.sv
`timescale 1ns/10ps
`include "decode_stage_config.svh"

module operand_bypass import decode_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               use_reg_i,
	input  logic [`REG_AW-1:0] addr_i,
	input  logic [`DATA_W-1:0] rf_data_i,
	input  logic [`DATA_W-1:0] imm_i,
	input  fwd_t               ex_fwd_i,
	input  fwd_t               mem_fwd_i,
	output logic [`DATA_W-1:0] operand_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit = ex_fwd_i.we && (ex_fwd_i.addr == addr_i);
	assign mem_hit = mem_fwd_i.we && (mem_fwd_i.addr == addr_i);

	always_comb begin
		if (!use_reg_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_fwd_i.data; // youngest result wins
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.data;
		end else begin
			operand_o = rf_data_i;
		end
	end

	// register file and forward paths must all be settled by then
	operand_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		use_reg_i |-> !$isunknown(operand_o));

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/10ps
`include "decode_stage_config.svh"

module inst_decoder import decode_pkg::*; (
	input  logic [`INST_W-1:0] inst_i,
	output dec_ctrl_t          ctrl_o
);

	logic [3:0]         memk;
	logic [7:0]         op;
	logic [`REG_AW-1:0] rd;
	logic [`REG_AW-1:0] rs1;
	logic [`REG_AW-1:0] rs2;
	logic [`DATA_W-1:0] imm;
	logic [`DATA_W-1:0] jtgt;
	aluop_e             alu_op;
	cond_e              br_cond;
	logic               is_alu;
	logic               is_br;

	assign memk = inst_i[`MEMK_HI:`MEMK_LO];
	assign op = inst_i[`OP_HI:`OP_LO];
	assign rd = inst_i[`RD_HI:`RD_LO];
	assign rs1 = inst_i[`RS1_HI:`RS1_LO];
	assign rs2 = inst_i[`RS2_HI:`RS2_LO];
	assign imm = inst_i[`IMM_HI:`IMM_LO];
	assign jtgt = inst_i[`JTGT_HI:`JTGT_LO];

	always_comb begin
		case (op)
			OP_OR:   alu_op = ALU_OR;
			OP_AND:  alu_op = ALU_AND;
			OP_XOR:  alu_op = ALU_XOR;
			OP_SHL:  alu_op = ALU_SHL;
			OP_SHR:  alu_op = ALU_SHR;
			OP_SAR:  alu_op = ALU_SAR;
			OP_ADD:  alu_op = ALU_ADD;
			OP_SUB:  alu_op = ALU_SUB;
			OP_JMP:  alu_op = ALU_JMP;
			OP_JE:   alu_op = ALU_JE;
			OP_JNE:  alu_op = ALU_JNE;
			OP_JG:   alu_op = ALU_JG;
			OP_JL:   alu_op = ALU_JL;
			OP_JNG:  alu_op = ALU_JNG;
			OP_JNL:  alu_op = ALU_JNL;
			default: alu_op = ALU_NOP;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_JNE: br_cond = CND_NE;
			ALU_JG:  br_cond = CND_GT;
			ALU_JL:  br_cond = CND_LT;
			ALU_JNG: br_cond = CND_LE;
			ALU_JNL: br_cond = CND_GE;
			default: br_cond = CND_EQ;
		endcase
	end

	assign is_alu = (alu_op != ALU_NOP) && (alu_op < ALU_JMP);
	assign is_br = alu_op > ALU_JMP; // compare branches only

	always_comb begin
		ctrl_o = '0;
		ctrl_o.rd = rd;
		ctrl_o.a_addr = rs1;
		ctrl_o.b_addr = rs2;
		ctrl_o.illegal = 1'b1;
		if (memk == MEMK_DREG && is_alu) begin
			ctrl_o.aluop = alu_op;
			ctrl_o.use_a = 1'b1;
			ctrl_o.use_b = 1'b1;
			ctrl_o.wreg = 1'b1;
			ctrl_o.illegal = 1'b0;
		end else if (memk == MEMK_SREG && is_alu) begin
			ctrl_o.aluop = alu_op;
			ctrl_o.use_a = 1'b1;
			ctrl_o.imm = imm;
			ctrl_o.wreg = 1'b1;
			ctrl_o.illegal = 1'b0;
		end else if (memk == MEMK_SREG && alu_op == ALU_JMP) begin
			ctrl_o.aluop = ALU_JMP;
			ctrl_o.imm = jtgt; // doubles as the target
			ctrl_o.is_jump = 1'b1;
			ctrl_o.illegal = 1'b0;
		end else if (memk == MEMK_SREG && is_br) begin
			// compare rd against rs1
			ctrl_o.aluop = alu_op;
			ctrl_o.use_a = 1'b1;
			ctrl_o.use_b = 1'b1;
			ctrl_o.a_addr = rd;
			ctrl_o.b_addr = rs1;
			ctrl_o.imm = imm;
			ctrl_o.is_cond = 1'b1;
			ctrl_o.cond = br_cond;
			ctrl_o.illegal = 1'b0;
		end
	end

endmodule

//--- source/branch_unit.sv
`timescale 1ns/10ps
`include "decode_stage_config.svh"

module branch_unit import decode_pkg::*; (
	input  dec_ctrl_t          ctrl_i,
	input  logic [`DATA_W-1:0] a_i,
	input  logic [`DATA_W-1:0] b_i,
	output logic               taken_o,
	output logic [`DATA_W-1:0] target_o
);

	logic [`DATA_W:0] diff;
	logic             borrow;
	logic             zero;
	logic             cond_met;

	assign diff = {1'b0, a_i} - {1'b0, b_i};
	assign borrow = diff[`DATA_W]; // set when a < b unsigned
	assign zero = (diff[`DATA_W-1:0] == '0);

	always_comb begin
		case (ctrl_i.cond)
			CND_EQ:  cond_met = zero;
			CND_NE:  cond_met = !zero;
			CND_GT:  cond_met = !borrow && !zero;
			CND_LT:  cond_met = borrow;
			CND_LE:  cond_met = borrow || zero;
			CND_GE:  cond_met = !borrow;
			default: cond_met = 1'b0;
		endcase
	end

	assign taken_o = ctrl_i.is_jump || (ctrl_i.is_cond && cond_met);
	assign target_o = taken_o ? ctrl_i.imm : '0;

endmodule

//--- source/decode_stage.sv
`timescale 1ns/10ps
`include "decode_stage_config.svh"

module decode_stage import decode_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       in_valid_i,
	output logic       in_ready_o,
	input  fetch_pkt_t in_pkt_i,
	input  fwd_t       ex_fwd_i,
	input  fwd_t       mem_fwd_i,
	input  fwd_t       wb_i,
	output logic       issue_valid_o,
	input  logic       issue_ready_i,
	output issue_pkt_t issue_pkt_o
);

	fetch_pkt_t         fet_pkt;
	logic               fet_valid;
	logic               iss_ready;
	dec_ctrl_t          ctrl;
	logic [`DATA_W-1:0] rf_a;
	logic [`DATA_W-1:0] rf_b;
	logic [`DATA_W-1:0] op_a;
	logic [`DATA_W-1:0] op_b;
	logic               taken;
	logic [`DATA_W-1:0] target;
	issue_pkt_t         iss_pkt;

	pipe_reg #(.payload_t(fetch_pkt_t)) u_fetch_reg (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_data_i   (in_pkt_i),
		.out_valid_o (fet_valid),
		.out_ready_i (iss_ready),
		.out_data_o  (fet_pkt)
	);

	inst_decoder u_decoder (
		.inst_i (fet_pkt.inst),
		.ctrl_o (ctrl)
	);

	reg_file u_reg_file (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.wr_i      (wb_i),
		.ra_addr_i (ctrl.a_addr),
		.rb_addr_i (ctrl.b_addr),
		.ra_data_o (rf_a),
		.rb_data_o (rf_b)
	);

	operand_bypass u_bypass_a (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.use_reg_i (ctrl.use_a),
		.addr_i    (ctrl.a_addr),
		.rf_data_i (rf_a),
		.imm_i     (ctrl.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (op_a)
	);

	operand_bypass u_bypass_b (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.use_reg_i (ctrl.use_b),
		.addr_i    (ctrl.b_addr),
		.rf_data_i (rf_b),
		.imm_i     (ctrl.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (op_b)
	);

	branch_unit u_branch (
		.ctrl_i   (ctrl),
		.a_i      (op_a),
		.b_i      (op_b),
		.taken_o  (taken),
		.target_o (target)
	);

	always_comb begin
		iss_pkt.aluop = ctrl.aluop;
		iss_pkt.a = op_a;
		iss_pkt.b = op_b;
		iss_pkt.rd = ctrl.rd;
		iss_pkt.wreg = ctrl.wreg;
		iss_pkt.branch = taken;
		iss_pkt.target = target;
		iss_pkt.illegal = ctrl.illegal;
	end

	pipe_reg #(.payload_t(issue_pkt_t)) u_issue_reg (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (fet_valid),
		.in_ready_o  (iss_ready),
		.in_data_i   (iss_pkt),
		.out_valid_o (issue_valid_o),
		.out_ready_i (issue_ready_i),
		.out_data_o  (issue_pkt_o)
	);

endmodule

//--- testbench/tb_decode_stage.sv
`timescale 1ns/10ps
`include "decode_stage_config.svh"

module tb_decode_stage import decode_pkg::*; ();

	logic       clk_i = 1'b0;
	logic       rst_n_i;
	logic       in_valid_i;
	logic       in_ready_o;
	fetch_pkt_t in_pkt_i;
	fwd_t       ex_fwd_i;
	fwd_t       mem_fwd_i;
	fwd_t       wb_i;
	logic       issue_valid_o;
	logic       issue_ready_i;
	issue_pkt_t issue_pkt_o;

	issue_pkt_t         exp_q[$];
	issue_pkt_t         mon_exp;
	string              lines[$];
	int                 err_cnt;
	int                 pkt_cnt;
	logic [`DATA_W-1:0] pc;

	decode_stage dut_i (.*);

	always #2 clk_i = ~clk_i;

	// random back-pressure
	always @(negedge clk_i) begin
		issue_ready_i = ($urandom % 32'd4) != 32'd0;
	end

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL %s: got %h expected %h (packet %0d)", name, got, exp, pkt_cnt);
		end
	endtask

	task automatic check_pkt(input issue_pkt_t exp);
		compare_field("aluop", {27'h0, issue_pkt_o.aluop}, {27'h0, exp.aluop});
		compare_field("a", issue_pkt_o.a, exp.a);
		compare_field("b", issue_pkt_o.b, exp.b);
		compare_field("rd", {27'h0, issue_pkt_o.rd}, {27'h0, exp.rd});
		compare_field("wreg", {31'h0, issue_pkt_o.wreg}, {31'h0, exp.wreg});
		compare_field("branch", {31'h0, issue_pkt_o.branch}, {31'h0, exp.branch});
		compare_field("target", issue_pkt_o.target, exp.target);
		compare_field("illegal", {31'h0, issue_pkt_o.illegal}, {31'h0, exp.illegal});
	endtask

	// output side, transfer decided mid low phase
	always @(negedge clk_i) begin
		#1;
		if (rst_n_i && issue_valid_o && issue_ready_i) begin
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("the DUT issued a packet that was not expected");
			end else begin
				mon_exp = exp_q.pop_front();
				check_pkt(mon_exp);
				pkt_cnt++;
			end
		end
	end

	// called at a falling edge, returns at the falling edge after acceptance
	task automatic drive_inst(input fetch_pkt_t pkt);
		in_valid_i = 1'b1;
		in_pkt_i = pkt;
		#1;
		while (!in_ready_o) begin
			@(negedge clk_i);
			#1;
		end
		@(negedge clk_i);
		in_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(negedge clk_i);
		end
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
		wb_i.we = 1'b1;
		wb_i.addr = addr[`REG_AW-1:0];
		wb_i.data = data;
		@(negedge clk_i);
		wb_i = '0;
	endtask

	initial begin
		int                 fd;
		string              line;
		logic [31:0]        v [0:12];
		longint             limit;
		fetch_pkt_t         pkt;
		issue_pkt_t         exp;

		void'($urandom(32'hceab_ca12));
		rst_n_i = 1'b0;
		in_valid_i = 1'b0;
		in_pkt_i = '0;
		ex_fwd_i = '0;
		mem_fwd_i = '0;
		wb_i = '0;
		issue_ready_i = 1'b1;
		err_cnt = 0;
		pkt_cnt = 0;
		pc = '0;

		fd = $fopen("testbench/decode_vectors.txt", "r");
		if (fd == 0) begin
			err_cnt++;
			$display("could not open the vector file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end

		limit = (longint'(lines.size()) * 200 + 100) * 4;
		fork
			begin
				#(limit);
				$display("timeout, the DUT stopped delivering packets");
				$display("ERRORS FOUND");
				$finish;
			end
		join_none

		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		#1;
		if (issue_valid_o !== 1'b0) begin
			err_cnt++;
			$display("FAIL issue_valid_o after reset: got %h expected 0", issue_valid_o);
		end
		if (in_ready_o !== 1'b1) begin
			err_cnt++;
			$display("FAIL in_ready_o after reset: got %h expected 1", in_ready_o);
		end
		@(negedge clk_i);

		foreach (lines[n]) begin
			line = lines[n];
			if (line[0] == "w") begin
				wait_drain();
				void'($sscanf(line, "w %h %h", v[0], v[1]));
				write_reg(v[0], v[1]);
			end else if (line[0] == "f") begin
				wait_drain(); // forwards move only with an empty pipe
				void'($sscanf(line, "f %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]));
				ex_fwd_i = '{we: v[0][0], addr: v[1][4:0], data: v[2]};
				mem_fwd_i = '{we: v[3][0], addr: v[4][4:0], data: v[5]};
			end else if (line[0] == "i") begin
				void'($sscanf(line, "i %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
					v[10], v[11], v[12]));
				pkt.inst = {v[0][3:0], v[1][7:0], v[2][4:0], v[3][4:0], v[4], 10'h0};
				pkt.pc = pc;
				pc = pc + 32'd8;
				exp.aluop = aluop_e'(v[5][4:0]);
				exp.a = v[6];
				exp.b = v[7];
				exp.rd = v[8][4:0];
				exp.wreg = v[9][0];
				exp.branch = v[10][0];
				exp.target = v[11];
				exp.illegal = v[12][0];
				exp_q.push_back(exp);
				drive_inst(pkt);
			end else begin
				err_cnt++;
				$display("unknown line kind in the vector file: %s", line);
			end
		end

		wait_drain();
		repeat (4) @(negedge clk_i);
		$display("packets checked: %0d, errors: %0d", pkt_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- testbench/decode_vectors.txt
# w addr data | f ex_we ex_addr ex_data mem_we mem_addr mem_data
# i memk op rd rs1 imm | aluop a b rd wreg branch target illegal (all hex)
w 01 11111111
w 02 80000000
w 03 7fffffff
w 04 00000005
w 05 80000005
w 06 80000000
i 2 10 07 01 10000000 07 11111111 80000000 07 1 0 0 0
i 2 03 08 03 20000000 03 7fffffff 00000005 08 1 0 0 0
i 1 11 09 04 00001234 08 00000005 00001234 09 1 0 0 0
i 1 05 0a 01 deadbeef 04 11111111 deadbeef 0a 1 0 0 0
i 2 01 1f 00 28000000 01 00000000 80000005 1f 1 0 0 0
i 1 02 02 02 0000ffff 02 80000000 0000ffff 02 1 0 0 0
i 2 06 03 05 08000000 05 80000005 11111111 03 1 0 0 0
i 1 07 04 06 0000001f 06 80000000 0000001f 04 1 0 0 0
f 1 01 aaaa0001 1 02 bbbb0002
i 2 10 07 01 10000000 07 aaaa0001 bbbb0002 07 1 0 0 0
f 1 01 aaaa0001 1 01 bbbb0001
i 2 10 07 01 10000000 07 aaaa0001 80000000 07 1 0 0 0
f 0 01 aaaa0001 1 01 bbbb0001
i 2 10 07 01 10000000 07 bbbb0001 80000000 07 1 0 0 0
i 1 01 06 01 00000f0f 01 bbbb0001 00000f0f 06 1 0 0 0
f 0 00 00000000 0 00 00000000
i 1 21 02 06 00000100 0a 80000000 80000000 02 0 1 00000100 0
i 1 22 02 06 00000100 0b 80000000 80000000 02 0 0 00000000 0
i 1 25 02 06 00000200 0e 80000000 80000000 02 0 1 00000200 0
i 1 26 02 06 00000200 0f 80000000 80000000 02 0 1 00000200 0
i 1 23 05 04 00000300 0c 80000005 00000005 05 0 1 00000300 0
i 1 24 05 04 00000300 0d 80000005 00000005 05 0 0 00000000 0
i 1 23 04 05 00000400 0c 00000005 80000005 04 0 0 00000000 0
i 1 24 04 05 00000400 0d 00000005 80000005 04 0 1 00000400 0
i 1 25 04 05 00000500 0e 00000005 80000005 04 0 1 00000500 0
i 1 26 04 05 00000500 0f 00000005 80000005 04 0 0 00000000 0
i 1 20 00 00 00400000 09 00001000 00001000 00 0 1 00001000 0
i 3 10 07 01 00000000 00 00000000 00000000 07 0 0 00000000 1
i 2 20 03 00 00000000 00 00000000 00000000 03 0 0 00000000 1
i 1 04 01 00 00000000 00 00000000 00000000 01 0 0 00000000 1

//--- decode_stage.f
+incdir+.
source/decode_pkg.sv
source/pipe_reg.sv
source/reg_file.sv
source/operand_bypass.sv
source/inst_decoder.sv
source/branch_unit.sv
source/decode_stage.sv
testbench/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_decode_stage \
	-f decode_stage.f -o sim_decode_stage
out=$(./obj_dir/sim_decode_stage)
echo "$out"
if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
else
	exit 1
fi
